// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cacheSubsystemTb
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MESSAGE ?= Test completed successfully
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulation status is ignored, the log decides pass or fail
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MESSAGE)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== build.f ====
+incdir+include
verilog/cachePkg.sv
verilog/cacheStore.sv
verilog/coherenceProtocol.sv
verilog/cpuController.sv
verilog/busInterconnect.sv
verilog/mainMemory.sv
verilog/cacheSubsystem.sv
sim/cacheSubsystemTb.sv

// ==== include/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// word address, one word per location
`define ADDR_WIDTH 16
`define DATA_WIDTH 32

// four words per line, sixteen lines
`define OFFSET_WIDTH 2
`define INDEX_WIDTH 4
`define TAG_WIDTH (`ADDR_WIDTH - `INDEX_WIDTH - `OFFSET_WIDTH)

// cycles from first sight of a request to done
`define MEM_LATENCY 3

`endif

// ==== sim/cacheSubsystemTb.sv ====
`timescale 1ns/1ps

module cacheSubsystemTb;
	import cachePkg::*;

	localparam int TIMEOUT_CYCLES = 200;

	logic clock;
	logic reset;
	cpuRequest_t cpuRequest;
	cpuResponse_t cpuResponse;
	memRequest_t externalRequest;
	memResponse_t externalResponse;

	// memory as the CPU sees it and memory as it really is
	word_t cpuView [address_t];
	word_t memView [address_t];

	logic [31:0] lfsrState = 32'hcd173918;
	time lastCpuDoneTime;
	time lastExtDoneTime;

	cacheSubsystem i_cacheSubsystem (
		.clock(clock),
		.reset(reset),
		.cpuRequest(cpuRequest),
		.cpuResponse(cpuResponse),
		.externalRequest(externalRequest),
		.externalResponse(externalResponse)
	);

	always #2 clock = ~clock;

	function automatic logic nextRandomBit();
		logic feedback;
		// taps 32, 22, 2, 1
		feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], feedback};
		return feedback;
	endfunction

	function automatic word_t randomWord();
		word_t value;
		value = '0;
		for (int i = 0; i < $bits(word_t); i++) begin
			value = {value[$bits(word_t) - 2 : 0], nextRandomBit()};
		end
		return value;
	endfunction

	function automatic address_t makeAddress(input tag_t tag, input index_t index,
		input offset_t offset);
		return {tag, index, offset};
	endfunction

	// untouched memory reads as zero
	function automatic word_t cpuExpected(input address_t address);
		if (cpuView.exists(address)) begin
			return cpuView[address];
		end else begin
			return '0;
		end
	endfunction

	function automatic word_t memExpected(input address_t address);
		if (memView.exists(address)) begin
			return memView[address];
		end else begin
			return '0;
		end
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic cpuAccess(input logic write, input address_t address, input word_t data,
		output word_t readData, output int cycles);
		@(negedge clock);
		cpuRequest = '{read: !write, write: write, address: address, writeData: data};
		cycles = 0;
		while (!cpuResponse.done && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			cycles++;
		end
		if (!cpuResponse.done) begin
			abortRun($sformatf("CPU got no done for address %h within %0d cycles",
				address, TIMEOUT_CYCLES));
		end else begin
			readData = cpuResponse.readData;
			lastCpuDoneTime = $time;
			cpuRequest = '0;
		end
	endtask

	task automatic extAccess(input logic write, input address_t address, input word_t data,
		output word_t readData);
		int cycles;
		@(negedge clock);
		externalRequest = '{read: !write, write: write, address: address, data: data};
		cycles = 0;
		while (!externalResponse.done && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			cycles++;
		end
		if (!externalResponse.done) begin
			abortRun($sformatf("external master got no done for address %h within %0d cycles",
				address, TIMEOUT_CYCLES));
		end else begin
			readData = externalResponse.data;
			lastExtDoneTime = $time;
			externalRequest = '0;
		end
	endtask

	task automatic cpuWrite(input address_t address, input word_t data);
		word_t unused;
		int cycles;
		cpuAccess(1'b1, address, data, unused, cycles);
		cpuView[address] = data;
	endtask

	// only used on lines the cache does not hold
	task automatic extWrite(input address_t address, input word_t data);
		word_t unused;
		extAccess(1'b1, address, data, unused);
		memView[address] = data;
		cpuView[address] = data;
	endtask

	task automatic checkCpuRead(input address_t address, output int cycles);
		word_t got;
		cpuAccess(1'b0, address, '0, got, cycles);
		assert (got === cpuExpected(address)) else begin
			abortRun($sformatf("ERR %0t: CPU read of %h returned %h, expected %h",
				$time, address, got, cpuExpected(address)));
		end
	endtask

	task automatic checkExtRead(input address_t address);
		word_t got;
		extAccess(1'b0, address, '0, got);
		assert (got === memExpected(address)) else begin
			abortRun($sformatf("ERR %0t: external read of %h returned %h, expected %h",
				$time, address, got, memExpected(address)));
		end
	endtask

	task automatic readMissThenHit();
		int cycles;
		for (int w = 0; w < 4; w++) begin
			extWrite(makeAddress(tag_t'(1), index_t'(2), offset_t'(w)), randomWord());
		end
		for (int w = 0; w < 4; w++) begin
			checkCpuRead(makeAddress(tag_t'(1), index_t'(2), offset_t'(w)), cycles);
		end
		checkCpuRead(makeAddress(tag_t'(1), index_t'(2), offset_t'(1)), cycles);
		assert (cycles <= 2) else begin
			abortRun($sformatf("ERR %0t: read hit took %0d cycles, expected at most 2",
				$time, cycles));
		end
	endtask

	task automatic writeMiss();
		int cycles;
		// the line holds data in memory that the fill has to bring in
		for (int w = 0; w < 4; w++) begin
			extWrite(makeAddress(tag_t'(3), index_t'(5), offset_t'(w)), randomWord());
		end
		cpuWrite(makeAddress(tag_t'(3), index_t'(5), offset_t'(1)), randomWord());
		for (int w = 0; w < 4; w++) begin
			checkCpuRead(makeAddress(tag_t'(3), index_t'(5), offset_t'(w)), cycles);
		end
	endtask

	task automatic sharedUpgrade();
		int cycles;
		for (int w = 0; w < 4; w++) begin
			extWrite(makeAddress(tag_t'(4), index_t'(7), offset_t'(w)), randomWord());
		end
		// the read fills to shared so the first write needs the invalidate
		checkCpuRead(makeAddress(tag_t'(4), index_t'(7), offset_t'(0)), cycles);
		for (int w = 0; w < 4; w++) begin
			cpuWrite(makeAddress(tag_t'(4), index_t'(7), offset_t'(w)), randomWord());
		end
		checkCpuRead(makeAddress(tag_t'(4), index_t'(7), offset_t'(2)), cycles);
		// modified line is not in memory yet
		checkExtRead(makeAddress(tag_t'(4), index_t'(7), offset_t'(2)));
	endtask

	task automatic dirtyEviction();
		int cycles;
		address_t victim;
		for (int w = 0; w < 4; w++) begin
			extWrite(makeAddress(tag_t'(6), index_t'(7), offset_t'(w)), randomWord());
		end
		checkCpuRead(makeAddress(tag_t'(6), index_t'(7), offset_t'(3)), cycles);
		// the write-back puts the CPU words of the victim in memory
		for (int w = 0; w < 4; w++) begin
			victim = makeAddress(tag_t'(4), index_t'(7), offset_t'(w));
			memView[victim] = cpuExpected(victim);
		end
		for (int w = 0; w < 4; w++) begin
			checkExtRead(makeAddress(tag_t'(4), index_t'(7), offset_t'(w)));
			checkCpuRead(makeAddress(tag_t'(6), index_t'(7), offset_t'(w)), cycles);
		end
	endtask

	task automatic busBackPressure();
		int cycles;
		time firstExtDone;
		time cpuDoneTime;
		for (int w = 0; w < 4; w++) begin
			extWrite(makeAddress(tag_t'(8), index_t'(11), offset_t'(w)), randomWord());
		end
		fork
			begin
				for (int i = 0; i < 6; i++) begin
					extWrite(makeAddress(tag_t'(20 + i), index_t'(9), offset_t'(0)),
						randomWord());
					if (i == 0) begin
						firstExtDone = lastExtDoneTime;
					end
				end
			end
			begin
				// miss arrives while the external master owns the bus
				repeat (2) @(negedge clock);
				checkCpuRead(makeAddress(tag_t'(8), index_t'(11), offset_t'(2)), cycles);
				cpuDoneTime = lastCpuDoneTime;
			end
		join
		assert (cpuDoneTime > firstExtDone) else begin
			abortRun($sformatf("ERR %0t: CPU done at %0t before external done at %0t",
				$time, cpuDoneTime, firstExtDone));
		end
		for (int w = 0; w < 4; w++) begin
			checkCpuRead(makeAddress(tag_t'(8), index_t'(11), offset_t'(w)), cycles);
		end
		for (int i = 0; i < 6; i++) begin
			checkExtRead(makeAddress(tag_t'(20 + i), index_t'(9), offset_t'(0)));
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		cpuRequest = '0;
		externalRequest = '0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		readMissThenHit();
		writeMiss();
		sharedUpgrade();
		dirtyEviction();
		busBackPressure();

		$display("Test completed successfully");
		$finish;
	end
endmodule : cacheSubsystemTb

// ==== verilog/busInterconnect.sv ====
`timescale 1ns/1ps

module busInterconnect (
	input logic clock,
	input logic reset,
	input cachePkg::memRequest_t cacheRequest,
	input cachePkg::memRequest_t externalRequest,
	input logic cacheBusRequest,
	input cachePkg::busCommand_t busCommand,
	output logic cacheGrant,
	output logic invalidateAck,
	output cachePkg::memResponse_t cacheResponse,
	output cachePkg::memResponse_t externalResponse,
	output cachePkg::memRequest_t memRequest,
	input cachePkg::memResponse_t memResponse
);
	import cachePkg::*;

	logic granted;
	// also remembers the last owner after release
	logic ownerIsExternal;
	logic externalWants;
	logic ownerRequesting;
	logic ownerPending;

	assign externalWants = externalRequest.read || externalRequest.write;
	assign ownerRequesting = ownerIsExternal ? externalWants : cacheBusRequest;

	always_ff @(posedge clock) begin
		if (reset) begin
			granted <= 1'b0;
			ownerIsExternal <= 1'b0;
		end else if (!(granted && ownerRequesting)) begin
			if (cacheBusRequest && externalWants) begin
				granted <= 1'b1;
				ownerIsExternal <= !ownerIsExternal;
			end else if (cacheBusRequest) begin
				granted <= 1'b1;
				ownerIsExternal <= 1'b0;
			end else if (externalWants) begin
				granted <= 1'b1;
				ownerIsExternal <= 1'b1;
			end else begin
				granted <= 1'b0;
			end
		end
	end

	assign cacheGrant = granted && !ownerIsExternal;
	// no other caches to answer, ack comes with the grant
	assign invalidateAck = cacheGrant && busCommand == BUS_INVALIDATE;

	assign memRequest = !granted ? '0 : (ownerIsExternal ? externalRequest : cacheRequest);

	assign cacheResponse = '{done: memResponse.done && cacheGrant, data: memResponse.data};
	assign externalResponse = '{
		done: memResponse.done && granted && ownerIsExternal,
		data: memResponse.data
	};

	assign ownerPending = granted && !memResponse.done
		&& (ownerIsExternal ? externalWants : (cacheRequest.read || cacheRequest.write));

	ownerHeldWhilePending: assert property (
		@(posedge clock) disable iff (reset)
		ownerPending |=> granted && ownerIsExternal == $past(ownerIsExternal)
	);
endmodule : busInterconnect

// ==== verilog/cachePkg.sv ====
`include "cache_cfg.svh"

package cachePkg;
	typedef logic [`ADDR_WIDTH - 1 : 0] address_t;
	typedef logic [`DATA_WIDTH - 1 : 0] word_t;
	typedef logic [`TAG_WIDTH - 1 : 0] tag_t;
	typedef logic [`INDEX_WIDTH - 1 : 0] index_t;
	typedef logic [`OFFSET_WIDTH - 1 : 0] offset_t;

	typedef enum logic [1 : 0] {
		INVALID,
		SHARED,
		MODIFIED
	} lineState_t;

	typedef enum logic [2 : 0] {
		NONE,
		BUS_READ,
		BUS_READ_EXCLUSIVE,
		BUS_WRITEBACK,
		BUS_INVALIDATE
	} busCommand_t;

	typedef struct packed {
		logic read;
		logic write;
		address_t address;
		word_t writeData;
	} cpuRequest_t;

	typedef struct packed {
		logic done;
		word_t readData;
	} cpuResponse_t;

	// one word per transaction on the memory bus
	typedef struct packed {
		logic read;
		logic write;
		address_t address;
		word_t data;
	} memRequest_t;

	typedef struct packed {
		logic done;
		word_t data;
	} memResponse_t;
endpackage : cachePkg

// ==== verilog/cacheStore.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cacheStore (
	input logic clock,
	input logic reset,
	input cachePkg::index_t index,
	input cachePkg::offset_t offset,
	input cachePkg::tag_t tagIn,
	input cachePkg::word_t dataIn,
	input cachePkg::lineState_t stateIn,
	input logic writeData,
	input logic writeTag,
	input logic writeState,
	output cachePkg::word_t dataOut,
	output cachePkg::tag_t tagOut,
	output cachePkg::lineState_t stateOut,
	output logic hit
);
	import cachePkg::*;

	tag_t tagArray [2**`INDEX_WIDTH];
	lineState_t stateArray [2**`INDEX_WIDTH];
	// word array indexed by line and word within the line
	word_t dataArray [2**(`INDEX_WIDTH + `OFFSET_WIDTH)];

	always_ff @(posedge clock) begin
		if (writeData) begin
			dataArray[{index, offset}] <= dataIn;
		end
		if (writeTag) begin
			tagArray[index] <= tagIn;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 2**`INDEX_WIDTH; i++) begin
				stateArray[i] <= INVALID;
			end
		end else if (writeState) begin
			stateArray[index] <= stateIn;
		end
	end

	assign dataOut = dataArray[{index, offset}];
	assign tagOut = tagArray[index];
	assign stateOut = stateArray[index];

	assign hit = (tagOut == tagIn) && (stateOut != INVALID);

	// a new tag always comes with the state of the new line
	tagWithState: assert property (
		@(posedge clock) disable iff (reset) writeTag |-> writeState
	);
endmodule : cacheStore

// ==== verilog/cacheSubsystem.sv ====
`timescale 1ns/1ps

module cacheSubsystem (
	input logic clock,
	input logic reset,
	input cachePkg::cpuRequest_t cpuRequest,
	output cachePkg::cpuResponse_t cpuResponse,
	input cachePkg::memRequest_t externalRequest,
	output cachePkg::memResponse_t externalResponse
);
	import cachePkg::*;

	memRequest_t cacheMemRequest;
	memResponse_t cacheMemResponse;
	memRequest_t memRequest;
	memResponse_t memResponse;
	busCommand_t busCommand;
	logic busRequest;
	logic busGrant;
	logic invalidateAck;

	cpuController i_cpuController (
		.clock(clock),
		.reset(reset),
		.cpuRequest(cpuRequest),
		.cpuResponse(cpuResponse),
		.memRequest(cacheMemRequest),
		.memResponse(cacheMemResponse),
		.busRequest(busRequest),
		.busGrant(busGrant),
		.invalidateAck(invalidateAck),
		.busCommand(busCommand)
	);

	busInterconnect i_busInterconnect (
		.clock(clock),
		.reset(reset),
		.cacheRequest(cacheMemRequest),
		.externalRequest(externalRequest),
		.cacheBusRequest(busRequest),
		.busCommand(busCommand),
		.cacheGrant(busGrant),
		.invalidateAck(invalidateAck),
		.cacheResponse(cacheMemResponse),
		.externalResponse(externalResponse),
		.memRequest(memRequest),
		.memResponse(memResponse)
	);

	mainMemory i_mainMemory (
		.clock(clock),
		.reset(reset),
		.memRequest(memRequest),
		.memResponse(memResponse)
	);
endmodule : cacheSubsystem

// ==== verilog/coherenceProtocol.sv ====
`timescale 1ns/1ps

module coherenceProtocol (
	input cachePkg::lineState_t stateOut,
	input logic hit,
	input logic read,
	input logic write,
	output logic writeBackRequired,
	output logic readExclusiveRequired,
	output logic invalidateRequired,
	output cachePkg::lineState_t stateIn
);
	import cachePkg::*;

	logic requested;

	assign requested = read || write;

	always_comb begin
		// victim is dirty, it goes back to memory first
		writeBackRequired = requested && !hit && stateOut == MODIFIED;
		readExclusiveRequired = !hit && write;
		// shared copy needs ownership before a write
		invalidateRequired = hit && write && stateOut == SHARED;

		if (write) begin
			stateIn = MODIFIED;
		end else if (read && !hit) begin
			stateIn = SHARED;
		end else begin
			stateIn = stateOut;
		end
	end
endmodule : coherenceProtocol

// ==== verilog/cpuController.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cpuController (
	input logic clock,
	input logic reset,
	input cachePkg::cpuRequest_t cpuRequest,
	output cachePkg::cpuResponse_t cpuResponse,
	output cachePkg::memRequest_t memRequest,
	input cachePkg::memResponse_t memResponse,
	output logic busRequest,
	input logic busGrant,
	input logic invalidateAck,
	output cachePkg::busCommand_t busCommand
);
	import cachePkg::*;

	typedef enum logic [1 : 0] {
		FILL_GRANT_WAIT,
		FILL_WAIT_DONE,
		FILL_WRITE_DATA,
		FILL_WRITE_TAG_STATE
	} fillState_t;

	typedef enum logic [1 : 0] {
		WB_GRANT_WAIT,
		WB_WAIT_DONE,
		WB_WRITE_STATE
	} writeBackState_t;

	typedef enum logic {
		INV_WAIT_ACK,
		INV_WRITE_STATE
	} invalidateState_t;

	fillState_t fillState;
	writeBackState_t writeBackState;
	invalidateState_t invalidateState;

	tag_t cpuTag;
	index_t cpuIndex;
	offset_t cpuOffset;
	tag_t masterTag;
	offset_t wordCounter;
	word_t fillData;

	logic memRead;
	logic memWrite;
	logic cpuDone;
	logic serving;
	logic requestPresent;

	logic cacheWriteData;
	logic cacheWriteTag;
	logic cacheWriteState;
	word_t cacheDataIn;
	word_t cacheDataOut;
	tag_t cacheTagOut;
	offset_t cacheOffset;
	lineState_t cacheStateIn;
	lineState_t cacheStateOut;
	lineState_t nextState;
	logic hit;

	logic writeBackRequired;
	logic readExclusiveRequired;
	logic invalidateRequired;

	assign cpuTag = cpuRequest.address[`ADDR_WIDTH - 1 -: `TAG_WIDTH];
	assign cpuIndex = cpuRequest.address[`OFFSET_WIDTH +: `INDEX_WIDTH];
	assign cpuOffset = cpuRequest.address[`OFFSET_WIDTH - 1 : 0];
	assign requestPresent = cpuRequest.read || cpuRequest.write;

	// line sequences walk the words with the counter
	assign cacheOffset = hit ? cpuOffset : wordCounter;
	assign cacheDataIn = hit ? cpuRequest.writeData : fillData;
	// evicted line drops to invalid before the fill
	assign cacheStateIn = (!hit && writeBackRequired) ? INVALID : nextState;
	assign masterTag = writeBackRequired ? cacheTagOut : cpuTag;

	assign memRequest = '{
		read: memRead,
		write: memWrite,
		address: {masterTag, cpuIndex, wordCounter},
		data: cacheDataOut
	};
	assign cpuResponse = '{done: cpuDone, readData: cacheDataOut};
	assign busRequest = busCommand != NONE;

	cacheStore i_cacheStore (
		.clock(clock),
		.reset(reset),
		.index(cpuIndex),
		.offset(cacheOffset),
		.tagIn(cpuTag),
		.dataIn(cacheDataIn),
		.stateIn(cacheStateIn),
		.writeData(cacheWriteData),
		.writeTag(cacheWriteTag),
		.writeState(cacheWriteState),
		.dataOut(cacheDataOut),
		.tagOut(cacheTagOut),
		.stateOut(cacheStateOut),
		.hit(hit)
	);

	coherenceProtocol i_coherenceProtocol (
		.stateOut(cacheStateOut),
		.hit(hit),
		.read(cpuRequest.read),
		.write(cpuRequest.write),
		.writeBackRequired(writeBackRequired),
		.readExclusiveRequired(readExclusiveRequired),
		.invalidateRequired(invalidateRequired),
		.stateIn(nextState)
	);

	always_comb begin
		busCommand = NONE;
		if (requestPresent) begin
			if (hit) begin
				if (invalidateRequired) begin
					busCommand = BUS_INVALIDATE;
				end
			end else if (writeBackRequired) begin
				busCommand = BUS_WRITEBACK;
			end else if (readExclusiveRequired) begin
				busCommand = BUS_READ_EXCLUSIVE;
			end else begin
				busCommand = BUS_READ;
			end
		end
	end

	// read and read-exclusive move the same words, only the final state differs
	task fillBlock();
		case (fillState)
			FILL_GRANT_WAIT: begin
				if (busGrant) begin
					memRead <= 1'b1;
					fillState <= FILL_WAIT_DONE;
				end
			end
			FILL_WAIT_DONE: begin
				if (memResponse.done) begin
					memRead <= 1'b0;
					fillData <= memResponse.data;
					cacheWriteData <= 1'b1;
					fillState <= FILL_WRITE_DATA;
				end
			end
			FILL_WRITE_DATA: begin
				cacheWriteData <= 1'b0;
				wordCounter <= wordCounter + 1'b1;
				if (&wordCounter) begin
					cacheWriteTag <= 1'b1;
					cacheWriteState <= 1'b1;
					fillState <= FILL_WRITE_TAG_STATE;
				end else begin
					fillState <= FILL_GRANT_WAIT;
				end
			end
			FILL_WRITE_TAG_STATE: begin
				cacheWriteTag <= 1'b0;
				cacheWriteState <= 1'b0;
				fillState <= FILL_GRANT_WAIT;
			end
			default: begin
				fillState <= FILL_GRANT_WAIT;
			end
		endcase
	endtask : fillBlock

	task writeBackBlock();
		case (writeBackState)
			WB_GRANT_WAIT: begin
				if (busGrant) begin
					memWrite <= 1'b1;
					writeBackState <= WB_WAIT_DONE;
				end
			end
			WB_WAIT_DONE: begin
				if (memResponse.done) begin
					memWrite <= 1'b0;
					wordCounter <= wordCounter + 1'b1;
					if (&wordCounter) begin
						cacheWriteState <= 1'b1;
						writeBackState <= WB_WRITE_STATE;
					end else begin
						writeBackState <= WB_GRANT_WAIT;
					end
				end
			end
			WB_WRITE_STATE: begin
				cacheWriteState <= 1'b0;
				writeBackState <= WB_GRANT_WAIT;
			end
			default: begin
				writeBackState <= WB_GRANT_WAIT;
			end
		endcase
	endtask : writeBackBlock

	task invalidateBlock();
		case (invalidateState)
			INV_WAIT_ACK: begin
				if (busGrant && invalidateAck) begin
					cacheWriteState <= 1'b1;
					invalidateState <= INV_WRITE_STATE;
				end
			end
			INV_WRITE_STATE: begin
				cacheWriteState <= 1'b0;
				invalidateState <= INV_WAIT_ACK;
			end
		endcase
	endtask : invalidateBlock

	// first cycle decides and arms the write, second one answers
	task serveRequest();
		if (serving) begin
			serving <= 1'b0;
			cacheWriteData <= 1'b0;
			cacheWriteState <= 1'b0;
			cpuDone <= 1'b1;
		end else if (!cpuDone) begin
			serving <= 1'b1;
			cacheWriteData <= cpuRequest.write;
			cacheWriteState <= cpuRequest.write;
		end
	endtask : serveRequest

	task controllerReset();
		fillState <= FILL_GRANT_WAIT;
		writeBackState <= WB_GRANT_WAIT;
		invalidateState <= INV_WAIT_ACK;
		wordCounter <= '0;
		memRead <= 1'b0;
		memWrite <= 1'b0;
		cpuDone <= 1'b0;
		serving <= 1'b0;
		cacheWriteData <= 1'b0;
		cacheWriteTag <= 1'b0;
		cacheWriteState <= 1'b0;
	endtask : controllerReset

	always_ff @(posedge clock) begin
		if (reset) begin
			controllerReset();
		end else begin
			cpuDone <= 1'b0;
			if (requestPresent) begin
				if (hit) begin
					if (invalidateRequired) begin
						invalidateBlock();
					end else begin
						serveRequest();
					end
				end else if (writeBackRequired) begin
					writeBackBlock();
				end else begin
					fillBlock();
				end
			end else begin
				serving <= 1'b0;
				cacheWriteData <= 1'b0;
				cacheWriteState <= 1'b0;
			end
		end
	end

	readWriteExclusive: assert property (
		@(posedge clock) disable iff (reset) !(memRequest.read && memRequest.write)
	);
endmodule : cpuController

// ==== verilog/mainMemory.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module mainMemory (
	input logic clock,
	input logic reset,
	input cachePkg::memRequest_t memRequest,
	output cachePkg::memResponse_t memResponse
);
	import cachePkg::*;

	localparam int COUNT_WIDTH = $clog2(`MEM_LATENCY + 1);
	localparam logic [COUNT_WIDTH - 1 : 0] LAST_COUNT = COUNT_WIDTH'(`MEM_LATENCY - 1);

	word_t memory [2**`ADDR_WIDTH] = '{default: '0};
	word_t readWord;
	logic [COUNT_WIDTH - 1 : 0] latencyCount;
	logic busy;
	logic done;
	logic finishing;

	assign finishing = busy && latencyCount == LAST_COUNT;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			latencyCount <= '0;
		end else begin
			done <= 1'b0;
			if (finishing) begin
				busy <= 1'b0;
				done <= 1'b1;
				latencyCount <= '0;
			end else if (busy) begin
				latencyCount <= latencyCount + 1'b1;
			end else if (!done && (memRequest.read || memRequest.write)) begin
				// request still held in the done cycle is the old one
				busy <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (finishing) begin
			if (memRequest.write) begin
				memory[memRequest.address] <= memRequest.data;
			end
			readWord <= memory[memRequest.address];
		end
	end

	assign memResponse = '{done: done, data: readWord};
endmodule : mainMemory
